// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = tb_tty_console
FILELIST  = tty_console.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// File: common/tty_pkg.sv
`default_nettype none

package tty_pkg;

  // widths of the values moved between the blocks
  localparam int word_width = 12;
  localparam int char_width = 8;
  localparam int apb_addr_width = 4;
  localparam int apb_data_width = 32;

  // accumulator word as written by the processor side
  typedef logic [word_width-1:0] word_t;
  // one serial character
  typedef logic [char_width-1:0] char_t;
  typedef logic [apb_addr_width-1:0] apb_addr_t;
  typedef logic [apb_data_width-1:0] apb_data_t;

  // line rate kept high so a character takes a few hundred clocks
  localparam int clock_frequency = 100_000_000;
  localparam int baud_rate = 6_250_000;
  localparam int bit_period = clock_frequency / baud_rate;

  // counter wide enough to hold a whole bit period
  localparam int period_width = $clog2(bit_period + 1);
  typedef logic [period_width-1:0] period_t;

  // reload values for the down counters
  localparam period_t period_last = period_t'(bit_period - 1);
  localparam period_t half_period_last = period_t'(bit_period / 2 - 1);

  // register offsets on the APB side
  localparam apb_addr_t addr_status = 4'h0;
  localparam apb_addr_t addr_control = 4'h4;
  localparam apb_addr_t addr_kbd_data = 4'h8;
  localparam apb_addr_t addr_caf = 4'hC;

  // status word bits
  localparam int status_tx_flag = 0;
  localparam int status_kbd_flag = 1;
  localparam int status_framing_error = 2;

  // control word bits, write only
  localparam int ctl_set_tx_flag = 0;
  localparam int ctl_clear_tx_flag = 1;
  localparam int ctl_clear_kbd_flag = 2;

endpackage

`default_nettype wire

// File: hdl/tty_apb_regs.sv
`default_nettype none

module tty_apb_regs (
  input  logic               clk100,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  tty_pkg::apb_addr_t paddr,
  input  tty_pkg::apb_data_t pwdata,
  output tty_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic               tx_flag,
  input  logic               kbd_flag,
  input  logic               framing_error,
  input  tty_pkg::char_t     kbd_char,
  output logic               load,
  output tty_pkg::word_t     tx_char,
  output logic               tx_set_flag,
  output logic               tx_clear_flag,
  output logic               kbd_clear_flag,
  output logic               clear
);
  import tty_pkg::*;

  logic       access;
  logic       wr;
  logic       rd;
  logic       legal;
  logic       wr_status;
  logic       wr_control;
  logic [4:0] cmd;

  // second cycle of a transfer, never any wait states
  assign access = psel && penable;
  assign wr = access && pwrite;
  assign rd = access && !pwrite;
  assign pready = access;

  assign wr_status = wr && (paddr == addr_status);
  assign wr_control = wr && (paddr == addr_control);

  // which offset takes which direction
  always_comb begin
    case (paddr)
      addr_status:   legal = 1'b1;
      addr_control:  legal = pwrite;
      addr_kbd_data: legal = !pwrite;
      addr_caf:      legal = pwrite;
      default:       legal = 1'b0;
    endcase
  end

  assign pslverr = access && !legal;

  // read mux
  always_comb begin
    prdata = '0;
    case (paddr)
      addr_status: begin
        prdata[status_tx_flag] = tx_flag;
        prdata[status_kbd_flag] = kbd_flag;
        prdata[status_framing_error] = framing_error;
      end
      addr_kbd_data: begin
        prdata[char_width-1:0] = kbd_char;
      end
      default: begin
        prdata = '0;
      end
    endcase
  end

  // command pulses, one clock each, a cycle after the access
  always_ff @(posedge clk100) begin
    if (reset) begin
      load <= 1'b0;
      tx_set_flag <= 1'b0;
      tx_clear_flag <= 1'b0;
      kbd_clear_flag <= 1'b0;
      clear <= 1'b0;
    end else begin
      // TLS
      load <= wr_status;
      tx_set_flag <= wr_control && pwdata[ctl_set_tx_flag];
      tx_clear_flag <= wr_control && pwdata[ctl_clear_tx_flag];
      // KRB read also drops the keyboard flag
      kbd_clear_flag <= (wr_control && pwdata[ctl_clear_kbd_flag]) ||
                        (rd && paddr == addr_kbd_data);
      // CAF
      clear <= wr && (paddr == addr_caf);
    end
  end

  // accumulator word travels with the load pulse
  always_ff @(posedge clk100) begin
    if (wr_status) begin
      tx_char <= pwdata[word_width-1:0];
    end
  end

  assign cmd = {load, tx_set_flag, tx_clear_flag, kbd_clear_flag, clear};

  // no command pulse is ever two clocks long
  assert property (@(posedge clk100) disable iff (reset)
    (cmd & $past(cmd)) == '0);

endmodule

`default_nettype wire

// File: hdl/tty_console.sv
`default_nettype none

module tty_console (
  input  logic               clk100,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  tty_pkg::apb_addr_t paddr,
  input  tty_pkg::apb_data_t pwdata,
  output tty_pkg::apb_data_t prdata,
  output logic               pready,
  output logic               pslverr,
  input  logic               rxd,
  output logic               txd
);
  import tty_pkg::*;

  // register block to printer
  logic  load;
  word_t tx_char;
  logic  tx_set_flag;
  logic  tx_clear_flag;
  logic  clear;
  // keyboard side
  logic  kbd_clear_flag;
  logic  kbd_flag;
  char_t kbd_char;
  logic  framing_error;
  logic  tx_flag;

  // stands in for the IOT decode of devices 03 and 04
  tty_apb_regs regs_i (
    .clk100         (clk100),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .tx_flag        (tx_flag),
    .kbd_flag       (kbd_flag),
    .framing_error  (framing_error),
    .kbd_char       (kbd_char),
    .load           (load),
    .tx_char        (tx_char),
    .tx_set_flag    (tx_set_flag),
    .tx_clear_flag  (tx_clear_flag),
    .kbd_clear_flag (kbd_clear_flag),
    .clear          (clear)
  );

  // teleprinter
  tty_tx tx_i (
    .clk100     (clk100),
    .reset      (reset),
    .clear      (clear),
    .char       (tx_char),
    .load       (load),
    .clear_flag (tx_clear_flag),
    .set_flag   (tx_set_flag),
    .flag       (tx_flag),
    .tx         (txd)
  );

  // keyboard
  tty_rx rx_i (
    .clk100        (clk100),
    .reset         (reset),
    .clear         (clear),
    .clear_flag    (kbd_clear_flag),
    .rx            (rxd),
    .flag          (kbd_flag),
    .char          (kbd_char),
    .framing_error (framing_error)
  );

endmodule

`default_nettype wire

// File: testbench/tb_tty_console.sv
`default_nettype none

module tb_tty_console;
  import tty_pkg::*;

  localparam int clk_period = 4;

  logic      clk100;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      txd;
  logic      rxd;

  // one entry per golden record
  logic [7:0] rec_op[$];
  apb_addr_t  rec_addr[$];
  apb_data_t  rec_data[$];
  apb_data_t  rec_exp[$];
  int         rec_test[$];

  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          checks;
  logic [31:0] seed;
  logic        records_loaded;

  tty_console tty_console_i (
    .clk100  (clk100),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rxd     (rxd),
    .txd     (txd)
  );

  // printer wired straight back into the keyboard
  assign rxd = txd;

  initial clk100 = 1'b0;
  always #(clk_period / 2) clk100 = ~clk100;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input apb_data_t got, input apb_data_t want);
    checks++;
    if (got !== want) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
      errors++;
      test_errors++;
    end
  endtask

  // setup cycle, access cycle, then back to idle
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t data,
                            output apb_data_t rdata, output logic err);
    @(posedge clk100);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= addr;
    pwdata <= data;
    // setup phase has no ready
    @(negedge clk100);
    check_value("pready", apb_data_t'(pready), 32'd0);
    @(posedge clk100);
    penable <= 1'b1;
    // middle of the access phase
    @(negedge clk100);
    check_value("pready", apb_data_t'(pready), 32'd1);
    rdata = prdata;
    err = pslverr;
    @(posedge clk100);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic poll_bit(input apb_addr_t addr, input int bit_idx, input logic want);
    apb_data_t rdata;
    logic      err;
    int        tries;
    tries = 0;
    // three clocks per read, roughly 18 bit periods in all
    do begin
      apb_access(1'b0, addr, '0, rdata, err);
      tries++;
    end while (rdata[bit_idx] !== want && tries < 6 * bit_period);
    if (rdata[bit_idx] !== want) begin
      $display("%0t: bit %0d at offset %h never reached %b", $time, bit_idx, addr, want);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_golden();
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    apb_addr_t  addr;
    apb_data_t  data;
    apb_data_t  exp;
    int         num;
    fd = $fopen("testbench/tty_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/tty_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // skip blank and comment lines
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h %d", op, addr, data, exp, num);
          if (n == 5) begin
            rec_op.push_back(op);
            rec_addr.push_back(addr);
            rec_data.push_back(data);
            rec_exp.push_back(exp);
            rec_test.push_back(num);
          end else begin
            $display("malformed golden line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
      if (rec_op.size() == 0) begin
        $display("golden file holds no records");
        errors++;
      end
    end
  endtask

  task automatic run_record(input int i);
    apb_data_t rdata;
    logic      err;
    case (rec_op[i])
      "w": begin
        apb_access(1'b1, rec_addr[i], rec_data[i], rdata, err);
        check_value("pslverr", apb_data_t'(err), rec_exp[i]);
      end
      "r": begin
        // data column holds the expected pslverr
        apb_access(1'b0, rec_addr[i], '0, rdata, err);
        check_value("pslverr", apb_data_t'(err), rec_data[i]);
        check_value("prdata", rdata, rec_exp[i]);
      end
      "p": begin
        poll_bit(rec_addr[i], int'(rec_data[i][4:0]), rec_exp[i][0]);
      end
      "b": begin
        repeat (rec_data[i] * bit_period) @(posedge clk100);
      end
      "t": begin
        @(posedge clk100);
        @(negedge clk100);
        check_value("txd", apb_data_t'(txd), rec_exp[i]);
      end
      default: begin
        $display("unknown golden operation '%c' in record %0d", rec_op[i], i);
        errors++;
        test_errors++;
      end
    endcase
  endtask

  task automatic report_test(input int num);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d finished with %0d mismatches", num, test_errors);
    test_errors = 0;
  endtask

  // budget of twelve bit periods per record
  initial begin
    wait (records_loaded);
    #((rec_op.size() + 1) * 12 * bit_period * clk_period);
    $display("watchdog expired before the golden records were done");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int cur_test;
    int i;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    reset = 1'b1;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    checks = 0;
    cur_test = 0;
    seed = 32'h5890;
    records_loaded = 1'b0;
    load_golden();
    records_loaded = 1'b1;
    repeat (8) @(posedge clk100);
    reset <= 1'b0;
    if (rec_op.size() > 0) begin
      cur_test = rec_test[0];
    end
    for (i = 0; i < rec_op.size(); i++) begin
      if (rec_test[i] != cur_test) begin
        report_test(cur_test);
        cur_test = rec_test[i];
      end
      // idle gap of zero to three clocks
      seed = lcg_next(seed);
      repeat (seed[17:16]) @(posedge clk100);
      run_record(i);
    end
    if (rec_op.size() > 0) begin
      report_test(cur_test);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tty_golden.txt
# op addr data expected test, all hex except test
# w write (expected=pslverr), r read (data=pslverr), p poll bit data until expected, b wait data bit periods, t txd
r 0 0 00000000 1
t 0 0 1 1
w 0 000000a5 0 2
p 0 0 1 2
p 0 1 1 2
r 8 0 000000a5 2
r 0 0 00000001 2
w 0 00000f3c 0 2
p 0 0 1 2
p 0 1 1 2
r 8 0 0000003c 2
r 0 0 00000001 2
w 4 00000002 0 3
r 0 0 00000000 3
w 4 00000001 0 3
r 0 0 00000001 3
w 0 00000055 0 3
p 0 1 1 3
w 4 00000004 0 3
r 0 0 00000001 3
w 0 00000123 0 4
w 0 000000cc 0 4
p 0 1 1 4
r 8 0 00000023 4
b 0 c 0 4
r 0 0 00000001 4
w 0 000000aa 0 5
b 0 3 0 5
w c 00000000 0 5
t 0 0 1 5
r 0 0 00000000 5
b 0 c 0 5
r 0 0 00000000 5
w 0 00000000 0 5
b 0 2 0 5
t 0 0 0 5
w c 00000000 0 5
t 0 0 1 5
w 4 00000001 0 6
r 0 0 00000001 6
w 8 12345678 1 6
r 4 1 00000000 6
r c 1 00000000 6
r 0 0 00000001 6

// File: tty_console.f
common/tty_pkg.sv
tty_tx/tty_tx.sv
tty_rx/tty_rx.sv
hdl/tty_apb_regs.sv
hdl/tty_console.sv
testbench/tb_tty_console.sv

// File: tty_rx/tty_rx.sv
`default_nettype none

module tty_rx (
  input  logic           clk100,
  input  logic           reset,
  input  logic           clear,
  input  logic           clear_flag,
  input  logic           rx,
  output logic           flag,
  output tty_pkg::char_t char,
  output logic           framing_error
);
  import tty_pkg::*;

  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } rx_state_t;

  rx_state_t  state;
  period_t    period_cntr;
  logic [2:0] bit_cnt;
  char_t      shifter;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  logic       fall;
  logic       sample;

  // line idles at mark, a falling edge is a possible start bit
  assign fall = rx_prev && !rx_sync;
  // middle of the current bit
  assign sample = (period_cntr == '0);

  // two flop synchroniser plus one more stage for edge detection
  always_ff @(posedge clk100) begin
    if (reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk100) begin
    if (state == data && sample) begin
      shifter <= {rx_sync, shifter[char_width-1:1]};
    end
  end

  // held character, overwritten even if the flag is still up
  always_ff @(posedge clk100) begin
    if (state == stop && sample) begin
      char <= shifter;
    end
  end

  always_ff @(posedge clk100) begin
    if (reset || clear) begin
      state <= idle;
      period_cntr <= '0;
      bit_cnt <= '0;
      flag <= 1'b0;
      framing_error <= 1'b0;
    end else begin
      if (clear_flag) begin
        flag <= 1'b0;
      end
      if (state != idle && !sample) begin
        period_cntr <= period_cntr - 1'b1;
      end

      case (state)
        idle: begin
          // half a bit to reach the middle of the start bit
          if (fall) begin
            state <= start;
            period_cntr <= half_period_last;
          end
        end
        start: begin
          if (sample) begin
            if (!rx_sync) begin
              state <= data;
              period_cntr <= period_last;
              bit_cnt <= '0;
            end else begin
              // glitch, line went back to mark
              state <= idle;
            end
          end
        end
        data: begin
          if (sample) begin
            period_cntr <= period_last;
            if (bit_cnt == 3'd7) begin
              state <= stop;
            end else begin
              bit_cnt <= bit_cnt + 3'd1;
            end
          end
        end
        stop: begin
          if (sample) begin
            // character is in, a low stop bit is a framing error
            flag <= 1'b1;
            framing_error <= !rx_sync;
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // keyboard flag only comes up from a completed frame
  assert property (@(posedge clk100) disable iff (reset)
    $rose(flag) |-> $past(state == stop));

endmodule

`default_nettype wire

// File: tty_tx/tty_tx.sv
`default_nettype none

module tty_tx (
  input  logic           clk100,
  input  logic           reset,
  input  logic           clear,
  input  tty_pkg::word_t char,
  input  logic           load,
  input  logic           clear_flag,
  input  logic           set_flag,
  output logic           flag,
  output logic           tx
);
  import tty_pkg::*;

  // order matters, the data states are stepped by adding one
  typedef enum logic [3:0] {
    idle,
    start,
    bit0,
    bit1,
    bit2,
    bit3,
    bit4,
    bit5,
    bit6,
    bit7,
    stop1,
    stop2
  } tx_state_t;

  tx_state_t state;
  period_t   period_cntr;
  char_t     tto;
  logic      loaded;
  logic      load_ok;
  logic      bit_done;

  // loads only land between characters and only one is held
  assign load_ok = load && !loaded && (state == idle || state == stop1 || state == stop2);
  // everything happens at the end of a state
  assign bit_done = (period_cntr == '0);

  // character shift copy
  // bit 0 leaves first, the top fills with mark
  always_ff @(posedge clk100) begin
    if (load_ok) begin
      tto <= char[char_width-1:0];
    end else if (bit_done && state inside {[start:bit6]}) begin
      tto <= {1'b1, tto[char_width-1:1]};
    end
  end

  always_ff @(posedge clk100) begin
    if (reset || clear) begin
      state <= idle;
      period_cntr <= period_t'(1);
      loaded <= 1'b0;
      flag <= 1'b0;
      tx <= 1'b1;
    end else begin
      // flag control from the register block
      if (clear_flag) begin
        flag <= 1'b0;
      end
      if (set_flag) begin
        flag <= 1'b1;
      end
      // a new character means printer busy
      if (load_ok) begin
        flag <= 1'b0;
        loaded <= 1'b1;
      end

      period_cntr <= period_cntr - 1'b1;

      if (bit_done) begin
        case (state)
          idle: begin
            if (loaded) begin
              // start bit goes on the line with the state change
              state <= start;
              period_cntr <= period_last;
              flag <= 1'b0;
              tx <= 1'b0;
            end else begin
              // poll again in two clocks
              period_cntr <= period_t'(1);
            end
          end
          start: begin
            // buffer free again once the start bit is done
            loaded <= 1'b0;
            state <= bit0;
            period_cntr <= period_last;
            tx <= tto[0];
          end
          bit0, bit1, bit2, bit3, bit4, bit5, bit6: begin
            state <= tx_state_t'(state + 4'd1);
            period_cntr <= period_last;
            tx <= tto[0];
          end
          bit7: begin
            // flag marks the last data bit, two stop bits still to go
            state <= stop1;
            period_cntr <= period_last;
            flag <= 1'b1;
            tx <= 1'b1;
          end
          stop1: begin
            state <= stop2;
            period_cntr <= period_last;
          end
          stop2: begin
            // a held load is picked up from idle
            state <= idle;
            period_cntr <= period_t'(1);
          end
          default: begin
            state <= idle;
            period_cntr <= period_t'(1);
            tx <= 1'b1;
          end
        endcase
      end
    end
  end

  // line is at space for the whole start bit
  assert property (@(posedge clk100) disable iff (reset)
    state == start |-> !tx);

  // the buffer stays empty while data bits go out
  assert property (@(posedge clk100) disable iff (reset)
    state inside {[bit0:bit7]} |-> !loaded);

endmodule

`default_nettype wire
